// File: list.f
verilog/dino_pkg.sv
verilog/object_box_if.sv
verilog/uart_cmd_rx.sv
verilog/dino_motion.sv
verilog/obstacle_motion.sv
verilog/game_referee.sv
verilog/dino_game_top.sv
bench/game_checker.sv
bench/tb_dino_game.sv

// File: Bender.yml
package:
  name: dino_game

sources:
  - verilog/dino_pkg.sv
  - verilog/object_box_if.sv
  - verilog/uart_cmd_rx.sv
  - verilog/dino_motion.sv
  - verilog/obstacle_motion.sv
  - verilog/game_referee.sv
  - verilog/dino_game_top.sv
  - target: test
    files:
      - bench/game_checker.sv
      - bench/tb_dino_game.sv

// File: bench/tb_dino_game.sv
`timescale 1ns/100ps
`default_nettype none

module tb_dino_game;
	import dino_pkg::*;

	localparam int NUM_TESTS = 8;
	localparam int ACTIONS_PER_TEST = 40;
	localparam int BIT_CLOCKS = 64;          // UART bit time in clocks
	localparam int MAX_ACTION_CLOCKS = 1024;  // Longest idle gap
	localparam int WATCHDOG_CYCLES =
		NUM_TESTS * (ACTIONS_PER_TEST * MAX_ACTION_CLOCKS + 1) + 7 + 2000;

	logic Clock;
	logic rst_n;
	logic uart_rx, key_jump, key_duck, restart;
	y_t dino_y;
	logic ducking;
	x_t obstacle_x;
	score_t score, high_score;
	logic game_over;
	logic cmd_pending;
	logic [7:0] cmd_byte;
	logic test_done;
	logic [7:0] test_num;
	int checks, errors, tests_failed;
	logic [31:0] rng_state;

	initial Clock = 1'b0;
	always #2 Clock = ~Clock;

	function automatic logic [31:0] galois_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// One LFSR step per random bit
	task automatic take_bits(input int n, output int value);
		value = 0;
		for (int i = 0; i < n; i++) begin
			value = (value << 1) | int'(rng_state[0]);
			rng_state = galois_next(rng_state);
		end
	endtask

	// Returns just after the edge, where the next drive happens
	task automatic wait_clocks(input int n);
		repeat (n) @(posedge Clock);
		#1;
	endtask

	task automatic send_uart_byte(input logic [7:0] b);
		cmd_byte = b;
		cmd_pending = 1'b1;
		uart_rx = 1'b0;  // Start bit
		wait_clocks(BIT_CLOCKS);
		for (int i = 0; i < 8; i++) begin
			uart_rx = b[i];
			wait_clocks(BIT_CLOCKS);
		end
		uart_rx = 1'b1;
		wait_clocks(3 * BIT_CLOCKS);  // Stop bit plus room for the first jump tick
		cmd_pending = 1'b0;
		wait_clocks(1);  // One quiet clock between back-to-back bytes
	endtask

	task automatic run_action;
		int kind;
		int amount;
		take_bits(3, kind);
		case (kind)
			3: begin
				take_bits(3, amount);
				key_jump = 1'b1;
				wait_clocks(amount + 1);
				key_jump = 1'b0;
				wait_clocks(32);
			end
			4: begin
				take_bits(3, amount);
				key_duck = 1'b1;
				wait_clocks(amount + 1);
				key_duck = 1'b0;
				wait_clocks(32);
			end
			5, 6: begin
				take_bits(2, amount);
				case (amount)
					0: send_uart_byte(CMD_JUMP);
					1: send_uart_byte(CMD_DUCK);
					2: send_uart_byte("X");  // Junk
					default: send_uart_byte("Q");
				endcase
			end
			7: begin
				if (game_over) begin
					restart = 1'b1;
					wait_clocks(1);
					restart = 1'b0;
				end
				wait_clocks(16);
			end
			default: begin
				take_bits(6, amount);
				wait_clocks(16 + amount * 16);
			end
		endcase
	endtask

	dino_game_top uut (
		.Clock(Clock),
		.rst_n(rst_n),
		.i_uart_rx(uart_rx),
		.i_key_jump(key_jump),
		.i_key_duck(key_duck),
		.i_restart(restart),
		.o_dino_y(dino_y),
		.o_ducking(ducking),
		.o_obstacle_x(obstacle_x),
		.o_score(score),
		.o_high_score(high_score),
		.o_game_over(game_over)
	);

	game_checker u_checker (
		.Clock(Clock),
		.rst_n(rst_n),
		.i_restart(restart),
		.i_key_jump(key_jump),
		.i_key_duck(key_duck),
		.i_cmd_pending(cmd_pending),
		.i_cmd_byte(cmd_byte),
		.i_test_done(test_done),
		.i_test_num(test_num),
		.i_dino_y(dino_y),
		.i_ducking(ducking),
		.i_obstacle_x(obstacle_x),
		.i_score(score),
		.i_high_score(high_score),
		.i_game_over(game_over),
		.o_checks(checks),
		.o_errors(errors),
		.o_tests_failed(tests_failed)
	);

	initial begin
		rng_state = 32'h47a1_52dd;
		rst_n = 1'b0;
		uart_rx = 1'b1;  // Line idles high
		key_jump = 1'b0;
		key_duck = 1'b0;
		restart = 1'b0;
		cmd_pending = 1'b0;
		cmd_byte = 8'h00;
		test_done = 1'b0;
		test_num = 8'd0;
		wait_clocks(5);
		rst_n = 1'b1;
		for (int t = 0; t < NUM_TESTS; t++) begin
			for (int a = 0; a < ACTIONS_PER_TEST; a++)
				run_action();
			test_num = 8'(t + 1);
			test_done = 1'b1;
			wait_clocks(1);
			test_done = 1'b0;
		end
		wait_clocks(2);
		$display("Tests %0d, failed %0d, checks %0d, errors %0d",
			NUM_TESTS, tests_failed, checks, errors);
		if (errors == 0 && tests_failed == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	// Watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge Clock);
		$display("Timeout after %0d cycles, the stimulus never finished", WATCHDOG_CYCLES);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/game_checker.sv
`timescale 1ns/100ps
`default_nettype none

// Watches the game ports and runs a cycle model of the game next to the DUT
module game_checker (
	input logic Clock,
	input logic rst_n,
	input logic i_restart,
	input logic i_key_jump,
	input logic i_key_duck,
	input logic i_cmd_pending,
	input logic [7:0] i_cmd_byte,
	input logic i_test_done,
	input logic [7:0] i_test_num,
	input dino_pkg::y_t i_dino_y,
	input logic i_ducking,
	input dino_pkg::x_t i_obstacle_x,
	input dino_pkg::score_t i_score,
	input dino_pkg::score_t i_high_score,
	input logic i_game_over,
	output int o_checks,
	output int o_errors,
	output int o_tests_failed
);
	import dino_pkg::*;

	// Model state for the current cycle, i.e. after the last rising edge
	y_t y;
	vel_t vel;
	logic air, duck, over, tick, respawn;
	int duck_cnt, tick_cnt, ny, test_errors;
	x_t x, prev_left;
	logic coll_d;
	score_t score, high;
	logic [15:0] lfsr;
	logic jm, js, dm, ds;    // Key synchroniser model
	logic tick_edge, was_live;  // What the last edge did
	logic c, pass, jgo, dgo;
	logic pend_d, eligible, obeyed;
	logic [7:0] pend_byte;

	function automatic logic [15:0] obstacle_lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[14] ^ s[12] ^ s[3]};
	endfunction

	// Inclusive AABB test of the dino box against the obstacle box
	function automatic logic boxes_overlap(input y_t dy, input logic dk, input x_t ox);
		x_t left;
		y_t top;
		y_t bot;
		left = DINO_X + DINO_X_OFS;
		top = dy + (dk ? DINO_TOP_DUCK : DINO_TOP_RUN);
		bot = top + (dk ? DINO_H_DUCK : DINO_H_RUN);
		return (left + DINO_W >= ox) && (left <= ox + OBS_W) &&
			(bot >= OBS_Y) && (top <= OBS_Y + OBS_H);
	endfunction

	task automatic compare_value(input string name, input int got, input int want);
		o_checks++;
		if (got != want) begin
			o_errors++;
			test_errors++;
			$display("FAIL %0t: %s is %0d, model expects %0d", $time, name, got, want);
		end
	endtask

	always @(negedge Clock) begin
		if (!rst_n) begin
			y = GROUND_Y;
			vel = '0;
			air = 1'b0;
			duck = 1'b0;
			duck_cnt = 0;
			x = OBS_START;
			prev_left = OBS_START;
			coll_d = 1'b0;
			lfsr = LFSR_SEED;
			tick = 1'b0;
			tick_cnt = 0;
			tick_edge = 1'b0;
			was_live = 1'b0;
			over = 1'b0;
			respawn = 1'b0;
			score = '0;
			high = '0;
			{jm, js, dm, ds} = 4'b0000;
			pend_d = 1'b0;
			eligible = 1'b0;
			obeyed = 1'b1;
			test_errors = 0;
			o_checks = 0;
			o_errors = 0;
			o_tests_failed = 0;
		end else begin
			if (i_cmd_pending && !pend_d) begin  // New UART byte on the line
				pend_byte = i_cmd_byte;
				eligible = 1'b1;
				obeyed = 1'b0;
			end
			// UART latency varies, so a command is taken when its effect shows
			if (i_cmd_pending && i_cmd_byte == CMD_JUMP && !obeyed && !air && !duck
				&& tick_edge && i_dino_y != y) begin
				ny = int'(GROUND_Y) + int'(JUMP_VEL);  // First tick of the jump
				y = ny[7:0];
				vel = JUMP_VEL + GRAVITY;
				air = 1'b1;
				obeyed = 1'b1;
			end
			if (i_cmd_pending && i_cmd_byte == CMD_DUCK && !obeyed && !air && !duck
				&& was_live && i_ducking) begin
				duck = 1'b1;
				duck_cnt = 0;
				obeyed = 1'b1;
			end

			compare_value("o_dino_y", i_dino_y, y);
			compare_value("o_ducking", i_ducking, duck);
			compare_value("o_obstacle_x", i_obstacle_x, x);
			compare_value("o_score", i_score, score);
			compare_value("o_high_score", i_high_score, high);
			compare_value("o_game_over", i_game_over, over);

			// An idle dino through the whole window must obey J and D
			if (i_cmd_pending && !obeyed)
				eligible = eligible && !air && !duck && !over;
			if (!i_cmd_pending && pend_d && eligible && !obeyed &&
				(pend_byte == CMD_JUMP || pend_byte == CMD_DUCK)) begin
				o_errors++;
				test_errors++;
				$display("At %0t the command byte %c was ignored by an idle dino",
					$time, pend_byte);
			end
			pend_d = i_cmd_pending;

			// State after the next edge
			c = boxes_overlap(y, duck, x);
			pass = (prev_left > DINO_X + DINO_X_OFS) && (x <= DINO_X + DINO_X_OFS)
				&& !c && !coll_d && !over;
			jgo = js && !air && !duck && !over;
			dgo = ds && !air && !duck && !jgo && !over;
			tick_edge = tick && !over && !i_restart;
			was_live = !over && !i_restart;
			prev_left = x;
			coll_d = c;
			js = jm;
			jm = i_key_jump;
			ds = dm;
			dm = i_key_duck;

			if (i_restart)
				x = OBS_START;
			else if (!over) begin
				if (respawn)
					x = XSCREEN - OBS_W + (lfsr[8:0] % RESPAWN_RANGE);
				else if (tick)
					x = (x <= 9'd1) ? XSCREEN - OBS_W : x - 9'd1;  // Wrap at left edge
			end
			lfsr = obstacle_lfsr_next(lfsr);

			if (i_restart) begin
				y = GROUND_Y;
				vel = '0;
				air = 1'b0;
			end else if (jgo) begin
				vel = JUMP_VEL;
				air = 1'b1;
			end else if (tick && air && !over) begin
				ny = int'(y) + int'(vel);
				if (ny >= int'(GROUND_Y)) begin
					y = GROUND_Y;  // Landing
					vel = '0;
					air = 1'b0;
				end else begin
					y = ny[7:0];
					vel = vel + GRAVITY;
				end
			end

			if (i_restart) begin
				duck = 1'b0;
				duck_cnt = 0;
			end else if (dgo) begin
				duck = 1'b1;
				duck_cnt = 0;
			end else if (duck && tick && !over) begin
				if (duck_cnt == DUCK_TICKS - 1)
					duck = 1'b0;
				duck_cnt++;
			end

			if (i_restart) begin
				tick = 1'b0;
				tick_cnt = 0;
			end else if (!over) begin
				tick = (tick_cnt == TICK_PERIOD - 1);
				tick_cnt = (tick_cnt + 1) % TICK_PERIOD;
			end else begin
				tick = 1'b0;
			end

			if (!i_restart && c && !over && score > high)
				high = score;
			if (i_restart) begin
				over = 1'b0;
				score = '0;
				respawn = 1'b0;
			end else begin
				respawn = pass;
				if (c)
					over = 1'b1;
				if (pass)
					score = score + 1'b1;
			end

			if (i_test_done) begin
				if (test_errors == 0)
					$display("Test %0d passed", i_test_num);
				else begin
					$display("Test %0d failed with %0d errors", i_test_num, test_errors);
					o_tests_failed++;
				end
				test_errors = 0;
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/dino_game_top.sv
`timescale 1ns/100ps
`default_nettype none

module dino_game_top (
	input logic Clock,
	input logic rst_n,
	input logic i_uart_rx,
	input logic i_key_jump,
	input logic i_key_duck,
	input logic i_restart,
	output dino_pkg::y_t o_dino_y,
	output logic o_ducking,
	output dino_pkg::x_t o_obstacle_x,
	output dino_pkg::score_t o_score,
	output dino_pkg::score_t o_high_score,
	output logic o_game_over
);

	logic jump_cmd, duck_cmd;
	logic tick;
	logic respawn;

	object_box_if dino_box ();
	object_box_if obs_box ();

	uart_cmd_rx u_cmd_rx (
		.Clock(Clock),
		.rst_n(rst_n),
		.i_rx(i_uart_rx),
		.o_jump_cmd(jump_cmd),
		.o_duck_cmd(duck_cmd)
	);

	dino_motion u_dino (
		.Clock(Clock),
		.rst_n(rst_n),
		.i_restart(i_restart),
		.i_key_jump(i_key_jump),
		.i_key_duck(i_key_duck),
		.i_jump_cmd(jump_cmd),
		.i_duck_cmd(duck_cmd),
		.i_tick(tick),
		.i_halt(o_game_over),
		.o_y(o_dino_y),
		.o_ducking(o_ducking),
		.o_box(dino_box.source)
	);

	obstacle_motion u_obstacle (
		.Clock(Clock),
		.rst_n(rst_n),
		.i_restart(i_restart),
		.i_tick(tick),
		.i_halt(o_game_over),
		.i_respawn(respawn),
		.o_x(o_obstacle_x),
		.o_box(obs_box.source)
	);

	// Game over is the referee halt level
	game_referee u_referee (
		.Clock(Clock),
		.rst_n(rst_n),
		.i_restart(i_restart),
		.i_dino_box(dino_box.sink),
		.i_obs_box(obs_box.sink),
		.o_tick(tick),
		.o_halt(o_game_over),
		.o_respawn(respawn),
		.o_score(o_score),
		.o_high_score(o_high_score)
	);

endmodule

`default_nettype wire

// File: verilog/game_referee.sv
`timescale 1ns/100ps
`default_nettype none

module game_referee (
	input logic Clock,
	input logic rst_n,
	input logic i_restart,
	object_box_if.sink i_dino_box,
	object_box_if.sink i_obs_box,
	output logic o_tick,
	output logic o_halt,
	output logic o_respawn,
	output dino_pkg::score_t o_score,
	output dino_pkg::score_t o_high_score
);
	import dino_pkg::*;

	logic [$clog2(TICK_PERIOD)-1:0] tick_cnt;
	logic collision;
	logic prev_collision;
	x_t prev_obs_left;
	logic pass;

	// Game tick held while the game is over
	always_ff @(posedge Clock) begin
		if (!rst_n || i_restart) begin
			tick_cnt <= '0;
			o_tick <= 1'b0;
		end else if (!o_halt) begin
			o_tick <= (tick_cnt == TICK_PERIOD - 1);
			if (tick_cnt == TICK_PERIOD - 1)
				tick_cnt <= '0;
			else
				tick_cnt <= tick_cnt + 1'b1;
		end else begin
			o_tick <= 1'b0;
		end
	end

	// AABB overlap with inclusive edges
	assign collision = (i_dino_box.right >= i_obs_box.left) &&
		(i_dino_box.left <= i_obs_box.right) &&
		(i_dino_box.bottom >= i_obs_box.top) &&
		(i_dino_box.top <= i_obs_box.bottom);

	// Obstacle slipped past the dino without touching it
	assign pass = (prev_obs_left > i_dino_box.left) && (i_obs_box.left <= i_dino_box.left)
		&& !collision && !prev_collision && !o_halt;

	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			prev_obs_left <= OBS_START;
			prev_collision <= 1'b0;
		end else begin
			prev_obs_left <= i_obs_box.left;
			prev_collision <= collision;
		end
	end

	always_ff @(posedge Clock) begin
		if (!rst_n || i_restart) begin
			o_halt <= 1'b0;
			o_score <= '0;
			o_respawn <= 1'b0;
		end else begin
			o_respawn <= pass;
			if (collision)
				o_halt <= 1'b1;  // Latched until restart
			if (pass)
				o_score <= o_score + 1'b1;
		end
	end

	// Best score survives restart
	always_ff @(posedge Clock) begin
		if (!rst_n)
			o_high_score <= '0;
		else if (!i_restart && collision && !o_halt && o_score > o_high_score)
			o_high_score <= o_score;
	end

endmodule

`default_nettype wire

// File: verilog/obstacle_motion.sv
`timescale 1ns/100ps
`default_nettype none

module obstacle_motion (
	input logic Clock,
	input logic rst_n,
	input logic i_restart,
	input logic i_tick,
	input logic i_halt,
	input logic i_respawn,
	output dino_pkg::x_t o_x,
	object_box_if.source o_box
);
	import dino_pkg::*;

	logic [15:0] lfsr;
	logic lfsr_fb;
	x_t wrap_x;
	x_t respawn_x;

	// Fibonacci LFSR free running from reset
	assign lfsr_fb = lfsr[15] ^ lfsr[14] ^ lfsr[12] ^ lfsr[3];

	always_ff @(posedge Clock) begin
		if (!rst_n)
			lfsr <= LFSR_SEED;
		else
			lfsr <= {lfsr[14:0], lfsr_fb};
	end

	assign wrap_x = XSCREEN - OBS_W;
	assign respawn_x = wrap_x + (lfsr[8:0] % RESPAWN_RANGE);  // Random distance past the edge

	always_ff @(posedge Clock) begin
		if (!rst_n || i_restart) begin
			o_x <= OBS_START;
		end else if (!i_halt) begin
			if (i_respawn)
				o_x <= respawn_x;
			else if (i_tick) begin
				if (o_x <= 9'd1)
					o_x <= wrap_x;  // Ran off the left edge
				else
					o_x <= o_x - 1'b1;
			end
		end
	end

	// Fixed height on the ground line
	assign o_box.left = o_x;
	assign o_box.right = o_x + OBS_W;
	assign o_box.top = OBS_Y;
	assign o_box.bottom = OBS_Y + OBS_H;

endmodule

`default_nettype wire

// File: verilog/dino_motion.sv
`timescale 1ns/100ps
`default_nettype none

module dino_motion (
	input logic Clock,
	input logic rst_n,
	input logic i_restart,
	input logic i_key_jump,
	input logic i_key_duck,
	input logic i_jump_cmd,
	input logic i_duck_cmd,
	input logic i_tick,
	input logic i_halt,
	output dino_pkg::y_t o_y,
	output logic o_ducking,
	object_box_if.source o_box
);
	import dino_pkg::*;

	logic jump_meta, jump_sync;
	logic duck_meta, duck_sync;
	logic jump_go, duck_go;
	logic airborne;
	vel_t vel;
	logic signed [9:0] next_y;
	logic [$clog2(DUCK_TICKS)-1:0] duck_cnt;
	y_t top_ofs, height;
	x_t box_left;
	y_t box_top;

	// Two-flop key synchronisers
	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			jump_meta <= 1'b0;
			jump_sync <= 1'b0;
			duck_meta <= 1'b0;
			duck_sync <= 1'b0;
		end else begin
			jump_meta <= i_key_jump;
			jump_sync <= jump_meta;
			duck_meta <= i_key_duck;
			duck_sync <= duck_meta;
		end
	end

	// A jump wins over a duck asked in the same cycle
	assign jump_go = (jump_sync | i_jump_cmd) && !airborne && !o_ducking && !i_halt;
	assign duck_go = (duck_sync | i_duck_cmd) && !airborne && !o_ducking && !jump_go
		&& !i_halt;

	assign next_y = $signed({2'b00, o_y}) + $signed({{4{vel[5]}}, vel});

	always_ff @(posedge Clock) begin
		if (!rst_n || i_restart) begin
			o_y <= GROUND_Y;
			vel <= '0;
			airborne <= 1'b0;
		end else if (jump_go) begin
			vel <= JUMP_VEL;
			airborne <= 1'b1;
		end else if (i_tick && airborne && !i_halt) begin
			if (next_y >= $signed({2'b00, GROUND_Y})) begin
				o_y <= GROUND_Y;  // Landed
				vel <= '0;
				airborne <= 1'b0;
			end else begin
				o_y <= next_y[7:0];
				vel <= vel + GRAVITY;
			end
		end
	end

	// Duck runs for a fixed number of ticks
	always_ff @(posedge Clock) begin
		if (!rst_n || i_restart) begin
			o_ducking <= 1'b0;
			duck_cnt <= '0;
		end else if (duck_go) begin
			o_ducking <= 1'b1;
			duck_cnt <= '0;
		end else if (o_ducking && i_tick && !i_halt) begin
			if (duck_cnt == DUCK_TICKS - 1)
				o_ducking <= 1'b0;
			duck_cnt <= duck_cnt + 1'b1;
		end
	end

	// Hit box shrinks from the top while ducking
	assign top_ofs = o_ducking ? DINO_TOP_DUCK : DINO_TOP_RUN;
	assign height = o_ducking ? DINO_H_DUCK : DINO_H_RUN;
	assign box_left = DINO_X + DINO_X_OFS;
	assign box_top = o_y + top_ofs;

	assign o_box.left = box_left;
	assign o_box.right = box_left + DINO_W;
	assign o_box.top = box_top;
	assign o_box.bottom = box_top + height;

endmodule

`default_nettype wire

// File: verilog/uart_cmd_rx.sv
`timescale 1ns/100ps
`default_nettype none

module uart_cmd_rx (
	input logic Clock,
	input logic rst_n,
	input logic i_rx,
	output logic o_jump_cmd,
	output logic o_duck_cmd
);
	import dino_pkg::*;

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

	logic [$clog2(OS_DIV)-1:0] div_cnt;
	logic os_tick;
	logic rx_meta, rx_sync;
	rx_state_t state;
	logic [3:0] os_cnt;   // Samples left until the next mid-bit
	logic [2:0] bit_idx;
	logic [7:0] shift;

	// 16x sample tick
	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			div_cnt <= '0;
			os_tick <= 1'b0;
		end else if (div_cnt == OS_DIV - 1) begin
			div_cnt <= '0;
			os_tick <= 1'b1;
		end else begin
			div_cnt <= div_cnt + 1'b1;
			os_tick <= 1'b0;
		end
	end

	// Line idles high
	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= i_rx;
			rx_sync <= rx_meta;
		end
	end

	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			state <= RX_IDLE;
			os_cnt <= 4'd0;
			bit_idx <= 3'd0;
			o_jump_cmd <= 1'b0;
			o_duck_cmd <= 1'b0;
		end else begin
			o_jump_cmd <= 1'b0;
			o_duck_cmd <= 1'b0;
			if (os_tick) begin
				case (state)
					RX_IDLE: if (!rx_sync) begin
						state <= RX_START;
						os_cnt <= 4'd7;  // Half a bit to mid start
					end
					RX_START: if (os_cnt == 4'd0) begin
						if (!rx_sync) begin
							state <= RX_DATA;
							os_cnt <= 4'd15;
							bit_idx <= 3'd0;
						end else begin
							state <= RX_IDLE;  // Glitch, not a start bit
						end
					end else begin
						os_cnt <= os_cnt - 1'b1;
					end
					RX_DATA: if (os_cnt == 4'd0) begin
						os_cnt <= 4'd15;
						if (bit_idx == 3'd7)
							state <= RX_STOP;
						else
							bit_idx <= bit_idx + 1'b1;
					end else begin
						os_cnt <= os_cnt - 1'b1;
					end
					RX_STOP: if (os_cnt == 4'd0) begin
						state <= RX_IDLE;
						// Framing error drops the byte
						if (rx_sync) begin
							o_jump_cmd <= (shift == CMD_JUMP);
							o_duck_cmd <= (shift == CMD_DUCK);
						end
					end else begin
						os_cnt <= os_cnt - 1'b1;
					end
					default: state <= RX_IDLE;
				endcase
			end
		end
	end

	// LSB arrives first
	always_ff @(posedge Clock) begin
		if (os_tick && state == RX_DATA && os_cnt == 4'd0)
			shift <= {rx_sync, shift[7:1]};
	end

endmodule

`default_nettype wire

// File: verilog/object_box_if.sv
`timescale 1ns/100ps
`default_nettype none

// Inclusive hit box edges of one game object
interface object_box_if;
	import dino_pkg::*;

	x_t left;
	x_t right;
	y_t top;
	y_t bottom;

	modport source (output left, right, top, bottom);
	modport sink (input left, right, top, bottom);

endinterface

`default_nettype wire

// File: verilog/dino_pkg.sv
`default_nettype none

package dino_pkg;

	// Coordinate and value types
	typedef logic [8:0] x_t;
	typedef logic [7:0] y_t;
	typedef logic [15:0] score_t;
	typedef logic signed [5:0] vel_t;  // Negative is upward

	// Screen and ground line
	localparam x_t XSCREEN = 9'd320;
	localparam y_t GROUND_Y = 8'd109;  // Dino y when standing

	// Jump physics applied once per game tick
	localparam vel_t JUMP_VEL = -6'sd10;
	localparam vel_t GRAVITY = 6'sd1;

	// Game pacing short enough for simulation
	localparam int TICK_PERIOD = 64;   // Clocks per game tick
	localparam int DUCK_TICKS = 24;    // Duck length in ticks

	// Dino hit box
	localparam x_t DINO_X = 9'd52;
	localparam x_t DINO_X_OFS = 9'd6;
	localparam x_t DINO_W = 9'd20;
	localparam y_t DINO_TOP_RUN = 8'd2;
	localparam y_t DINO_H_RUN = 8'd28;
	localparam y_t DINO_TOP_DUCK = 8'd16;  // Ducking lowers the head
	localparam y_t DINO_H_DUCK = 8'd16;

	// Obstacle hit box and placement
	localparam y_t OBS_Y = 8'd102;
	localparam x_t OBS_W = 9'd16;
	localparam y_t OBS_H = 8'd16;
	localparam x_t OBS_START = 9'd320;
	localparam x_t RESPAWN_RANGE = 9'd100;  // Spread of respawn offsets

	localparam logic [15:0] LFSR_SEED = 16'hACE1;

	// UART receiver
	localparam int OS_DIV = 4;  // Clocks per 16x sample tick
	localparam logic [7:0] CMD_JUMP = "J";
	localparam logic [7:0] CMD_DUCK = "D";

endpackage

`default_nettype wire
